// ==== ctrl_pkg.sv ====
package ctrl_pkg;

    // instruction sequencing
    localparam int seq_len    = 10;  // steps per instruction, fetch + decode + execute
    localparam int fetch_end  = 1;   // last fetch step, ir loads as it ends
    localparam int decode_end = 3;   // last decode step, execute starts after it

    localparam logic [seq_len-1:0] seq_step0 = 1;  // ring value after reset

    // widths
    localparam int rom_width  = 24;  // one microcode rom word
    localparam int addr_width = 16;  // address bus
    localparam int data_width = 8;   // data bus, immediate byte

    // instruction word layout
    localparam int op_lsb   = 21;  // opcode lives in rom[23:21]
    localparam int mode_bit = 2;   // opcode bit 2 == rom bit 23, 0 register / 1 immediate

    // opcodes, 0..2 use register addressing and 4..6 immediate
    typedef enum logic [2:0] {
        op_dev_eq_alu      = 3'd0,  // dev = lbus <aluop> rbus
        op_dev_eq_const8   = 3'd1,  // dev = rom[7:0]
        op_devp_eq_const16 = 3'd2,  // pair load, only the low byte goes out here
        op_dev_eq_rom_abs  = 3'd4,  // dev = rom[abs]
        op_dev_eq_ram_abs  = 3'd5,  // dev = ram[abs]
        op_ram_abs_eq_dev  = 3'd6   // ram[abs] = dev
    } ctrl_op_e;

    // bus devices, same encoding on left and right bus
    typedef enum logic [3:0] {
        bus_rom   = 4'h0,
        bus_ram   = 4'h1,
        bus_rega  = 4'h2,
        bus_regb  = 4'h3,
        bus_regc  = 4'h4,
        bus_regd  = 4'h5,
        bus_marlo = 4'h6,
        bus_marhi = 4'h7,
        bus_uart  = 4'h8,
        bus_none  = 4'hF   // nobody drives
    } bus_dev_e;

    // write targets, unnamed codes come straight from the instruction
    typedef enum logic [4:0] {
        targ_rega  = 5'h00,
        targ_regb  = 5'h01,
        targ_regc  = 5'h02,
        targ_regd  = 5'h03,
        targ_marlo = 5'h04,
        targ_marhi = 5'h05,
        targ_uart  = 5'h06,
        targ_ram   = 5'h08,
        targ_none  = 5'h1F  // no write strobe
    } targ_dev_e;

    // alu operations, unnamed codes pass through as well
    typedef enum logic [4:0] {
        alu_zero  = 5'h00,
        alu_passl = 5'h01,  // result = lbus
        alu_passr = 5'h02,  // result = rbus
        alu_add   = 5'h03,
        alu_sub   = 5'h04,
        alu_and   = 5'h05,
        alu_or    = 5'h06,
        alu_xor   = 5'h07
    } alu_op_e;

endpackage

// ==== phaser.sv ====
module phaser (
    input  logic                         clk,
    input  logic                         arst_n,
    output logic [ctrl_pkg::seq_len-1:0] seq,          // one-hot step
    output logic                         phase_fetch,  // steps 0-1
    output logic                         phase_decode, // steps 2-3
    output logic                         phase_exec    // steps 4-9
);

    logic seq_legal;  // exactly one bit set

    // nonzero and no second bit left after clearing the lowest one
    assign seq_legal = (seq != '0) && ((seq & (seq - 1'b1)) == '0);

    // ring of seq_len flops, rotates left once per clock
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            seq <= ctrl_pkg::seq_step0;  // start in fetch
        end else if (!seq_legal) begin
            // a corrupted ring recovers at the start of an instruction
            seq <= ctrl_pkg::seq_step0;
        end else begin
            seq <= {seq[ctrl_pkg::seq_len-2:0], seq[ctrl_pkg::seq_len-1]};
        end
    end

    // phase levels from fixed step groups
    assign phase_fetch  = |seq[ctrl_pkg::fetch_end:0];
    assign phase_decode = |seq[ctrl_pkg::decode_end:ctrl_pkg::fetch_end+1];
    assign phase_exec   = |seq[ctrl_pkg::seq_len-1:ctrl_pkg::decode_end+1];

endmodule

// ==== fetch_unit.sv ====
module fetch_unit (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic [ctrl_pkg::seq_len-1:0]    seq,       // one-hot step from phaser
    input  logic [ctrl_pkg::rom_width-1:0]  rom_data,  // word at rom[pc]
    output logic [ctrl_pkg::addr_width-1:0] pc,        // rom address during fetch
    output ctrl_pkg::ctrl_op_e              ir_op,     // ir[23:21]
    output logic [4:0]                      ir_hi,     // ir[20:16], target or lbus source
    output logic [ctrl_pkg::addr_width-1:0] ir_lo      // ir[15:0], fields or address
);

    logic [ctrl_pkg::rom_width-1:0] ir;  // latched instruction word

    // program counter
    // moves on the edge that ends the last execute step, so the address
    // is already stable when the next fetch begins
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else if (seq[ctrl_pkg::seq_len-1]) begin
            pc <= pc + 1'b1;  // straight line code only, no jumps
        end
    end

    // instruction register
    // rom_data is only trusted at the end of fetch; during execute the rom
    // address bus may carry a data address and rom_data changes under us
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ir <= '0;
        end else if (seq[ctrl_pkg::fetch_end]) begin
            ir <= rom_data;
        end
    end

    // field split
    assign ir_op = ctrl_pkg::ctrl_op_e'(ir[ctrl_pkg::rom_width-1:ctrl_pkg::op_lsb]);
    assign ir_hi = ir[ctrl_pkg::op_lsb-1:ctrl_pkg::addr_width];
    assign ir_lo = ir[ctrl_pkg::addr_width-1:0];  // also the direct address

endmodule

// ==== control_selector.sv ====
module control_selector (
    input  ctrl_pkg::ctrl_op_e              ir_op,
    input  logic [4:0]                      ir_hi,
    input  logic [ctrl_pkg::addr_width-1:0] ir_lo,
    input  logic                            phase_fetch,
    input  logic                            phase_exec,
    output ctrl_pkg::bus_dev_e              rbus_dev,             // right bus driver
    output ctrl_pkg::bus_dev_e              lbus_dev,             // left bus driver
    output ctrl_pkg::targ_dev_e             targ_dev,             // write target
    output ctrl_pkg::alu_op_e               aluop,
    output logic                            addrmode_pc_n,        // pc onto address bus
    output logic                            addrmode_register_n,  // mar onto address bus
    output logic                            addrmode_direct_n,    // ir[15:0] onto address bus
    output logic [ctrl_pkg::addr_width-1:0] direct_addr,
    output logic [ctrl_pkg::data_width-1:0] imm8                  // constant for rom bus device
);

    logic                addr_mode;  // 0 register, 1 immediate
    ctrl_pkg::bus_dev_e  rbus_sel;   // decoded, before phase gating
    ctrl_pkg::bus_dev_e  lbus_sel;
    ctrl_pkg::targ_dev_e targ_sel;

    // address mode enables
    assign addr_mode = ir_op[ctrl_pkg::mode_bit];

    // fetch always addresses through the pc; after that the opcode picks
    // mar or the immediate field, so exactly one enable is low at any time
    assign addrmode_pc_n       = ~phase_fetch;
    assign addrmode_register_n = phase_fetch | addr_mode;
    assign addrmode_direct_n   = phase_fetch | ~addr_mode;

    // opcode decode
    always_comb begin
        // defaults are the no-op values, opcodes 3 and 7 keep them
        rbus_sel = ctrl_pkg::bus_none;
        lbus_sel = ctrl_pkg::bus_none;
        aluop    = ctrl_pkg::alu_passr;
        targ_sel = ctrl_pkg::targ_none;
        case (ir_op)
            ctrl_pkg::op_dev_eq_alu: begin
                rbus_sel = ctrl_pkg::bus_dev_e'(ir_lo[8:5]);
                lbus_sel = ctrl_pkg::bus_dev_e'(ir_lo[12:9]);
                aluop    = ctrl_pkg::alu_op_e'(ir_lo[4:0]);
                targ_sel = ctrl_pkg::targ_dev_e'(ir_hi);
            end
            ctrl_pkg::op_dev_eq_const8,
            ctrl_pkg::op_devp_eq_const16,
            ctrl_pkg::op_dev_eq_rom_abs: begin
                rbus_sel = ctrl_pkg::bus_rom;  // constant or rom[abs] comes in on rbus
                targ_sel = ctrl_pkg::targ_dev_e'(ir_hi);
            end
            ctrl_pkg::op_dev_eq_ram_abs: begin
                rbus_sel = ctrl_pkg::bus_ram;
                targ_sel = ctrl_pkg::targ_dev_e'(ir_hi);
            end
            ctrl_pkg::op_ram_abs_eq_dev: begin
                // source register on lbus, ram is written
                lbus_sel = ctrl_pkg::bus_dev_e'(ir_hi[3:0]);
                aluop    = ctrl_pkg::alu_passl;
                targ_sel = ctrl_pkg::targ_ram;
            end
            default: begin
                // unused opcode, nothing moves
            end
        endcase
    end

    // phase gating
    // ir is fresh from decode on, but bus drivers and the write strobe wait
    // for execute so a half settled word never reaches the datapath
    assign rbus_dev = phase_exec ? rbus_sel : ctrl_pkg::bus_none;
    assign lbus_dev = phase_exec ? lbus_sel : ctrl_pkg::bus_none;
    assign targ_dev = phase_exec ? targ_sel : ctrl_pkg::targ_none;

    // immediate fields
    assign direct_addr = ir_lo;                         // absolute ram / rom address
    assign imm8        = ir_lo[ctrl_pkg::data_width-1:0];  // const8 byte

endmodule

// ==== cpu_control.sv ====
module cpu_control (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic [ctrl_pkg::rom_width-1:0]  rom_data,
    output logic [ctrl_pkg::addr_width-1:0] pc,
    output ctrl_pkg::bus_dev_e              rbus_dev,
    output ctrl_pkg::bus_dev_e              lbus_dev,
    output ctrl_pkg::targ_dev_e             targ_dev,
    output ctrl_pkg::alu_op_e               aluop,
    output logic                            addrmode_pc_n,
    output logic                            addrmode_register_n,
    output logic                            addrmode_direct_n,
    output logic [ctrl_pkg::addr_width-1:0] direct_addr,
    output logic [ctrl_pkg::data_width-1:0] imm8
);

    logic [ctrl_pkg::seq_len-1:0]    seq;          // current step
    logic                            phase_fetch;
    logic                            phase_exec;
    ctrl_pkg::ctrl_op_e              ir_op;        // latched opcode
    logic [4:0]                      ir_hi;
    logic [ctrl_pkg::addr_width-1:0] ir_lo;

    // step sequencer, decode level is not consumed in this control path
    phaser phaser_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .seq          (seq),
        .phase_fetch  (phase_fetch),
        .phase_decode (),
        .phase_exec   (phase_exec)
    );

    fetch_unit fetch_unit_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .seq      (seq),
        .rom_data (rom_data),
        .pc       (pc),
        .ir_op    (ir_op),
        .ir_hi    (ir_hi),
        .ir_lo    (ir_lo)
    );

    control_selector control_selector_inst (
        .ir_op               (ir_op),
        .ir_hi               (ir_hi),
        .ir_lo               (ir_lo),
        .phase_fetch         (phase_fetch),
        .phase_exec          (phase_exec),
        .rbus_dev            (rbus_dev),
        .lbus_dev            (lbus_dev),
        .targ_dev            (targ_dev),
        .aluop               (aluop),
        .addrmode_pc_n       (addrmode_pc_n),
        .addrmode_register_n (addrmode_register_n),
        .addrmode_direct_n   (addrmode_direct_n),
        .direct_addr         (direct_addr),
        .imm8                (imm8)
    );

endmodule

// ==== cpu_control_assertions.sv ====
module cpu_control_assertions (
    input logic                            clk,
    input logic                            arst_n,
    input logic [ctrl_pkg::seq_len-1:0]    seq,
    input logic [ctrl_pkg::addr_width-1:0] pc,
    input ctrl_pkg::targ_dev_e             targ_dev,
    input logic                            addrmode_pc_n,
    input logic                            addrmode_register_n,
    input logic                            addrmode_direct_n
);

    int failures = 0;  // failed properties so far, read by the testbench at the end

    // ring never loses or gains a bit
    a_seq_onehot: assert property (@(posedge clk) disable iff (!arst_n) $onehot(seq))
        else begin
            $error("seq is not one-hot: %h", seq);
            failures++;
        end

    // one driver on the address bus, reset included
    // the pc drives it on steps 0 and 1 and on no other step
    a_one_enable: assert property (@(posedge clk)
        $onehot({~addrmode_pc_n, ~addrmode_register_n, ~addrmode_direct_n})
        && (addrmode_pc_n == !(seq[0] || seq[1])))
        else begin
            $error("address enables not exclusive or pc enable off its fetch steps");
            failures++;
        end

    // no write strobe from a stale word, fetch and decode steps stay quiet
    a_targ_idle: assert property (@(posedge clk) disable iff (!arst_n)
        (|seq[ctrl_pkg::decode_end:0]) |-> targ_dev == ctrl_pkg::targ_none)
        else begin
            $error("targ_dev active outside execute: %h", targ_dev);
            failures++;
        end

    a_pc_step: assert property (@(posedge clk) disable iff (!arst_n)
        seq[ctrl_pkg::seq_len-1] |=> pc == $past(pc) + 16'd1)
        else begin
            $error("pc did not step after the last execute step");
            failures++;
        end

    a_pc_hold: assert property (@(posedge clk) disable iff (!arst_n)
        !seq[ctrl_pkg::seq_len-1] |=> pc == $past(pc))
        else begin
            $error("pc moved in the middle of an instruction");
            failures++;
        end

endmodule

bind cpu_control cpu_control_assertions cpu_control_assertions_inst (
    .clk                 (clk),
    .arst_n              (arst_n),
    .seq                 (seq),
    .pc                  (pc),
    .targ_dev            (targ_dev),
    .addrmode_pc_n       (addrmode_pc_n),
    .addrmode_register_n (addrmode_register_n),
    .addrmode_direct_n   (addrmode_direct_n)
);

// ==== tb_cpu_control.sv ====
module tb_cpu_control;

    localparam int reset_cycles  = 8;
    localparam int fetch_timeout = 20;  // cycles to wait for a fetch phase
    localparam int hold_timeout  = 4;   // fetch is two steps long
    localparam int exec_timeout  = 3;   // decode is two steps, a bit of slack

    logic                            clk;
    logic                            arst_n;
    logic [ctrl_pkg::rom_width-1:0]  rom_data;   // the testbench plays the rom
    logic [ctrl_pkg::addr_width-1:0] pc;
    ctrl_pkg::bus_dev_e              rbus_dev;
    ctrl_pkg::bus_dev_e              lbus_dev;
    ctrl_pkg::targ_dev_e             targ_dev;
    ctrl_pkg::alu_op_e               aluop;
    logic                            addrmode_pc_n;
    logic                            addrmode_register_n;
    logic                            addrmode_direct_n;
    logic [ctrl_pkg::addr_width-1:0] direct_addr;
    logic [ctrl_pkg::data_width-1:0] imm8;

    logic [31:0] lfsr;          // garbage source
    int          errors;
    int          timeouts;
    int          assert_fails;  // failures seen by the bound checker
    int          lines_run;     // instructions taken from the golden file

    cpu_control cpu_control_inst (
        .clk                 (clk),
        .arst_n              (arst_n),
        .rom_data            (rom_data),
        .pc                  (pc),
        .rbus_dev            (rbus_dev),
        .lbus_dev            (lbus_dev),
        .targ_dev            (targ_dev),
        .aluop               (aluop),
        .addrmode_pc_n       (addrmode_pc_n),
        .addrmode_register_n (addrmode_register_n),
        .addrmode_direct_n   (addrmode_direct_n),
        .direct_addr         (direct_addr),
        .imm8                (imm8)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // period 40
    end

    // x^32 + x^22 + x^2 + x + 1, shift left, new bit in at the bottom
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit of the rom word
    task automatic drive_garbage();
        logic [ctrl_pkg::rom_width-1:0] w;
        int                             i;
        w = '0;
        for (i = 0; i < ctrl_pkg::rom_width; i++) begin
            lfsr = lfsr_next(lfsr);
            w    = {w[ctrl_pkg::rom_width-2:0], lfsr[0]};
        end
        rom_data = w;
    endtask

    task automatic check_bus(input string name, input ctrl_pkg::bus_dev_e got,
                             input ctrl_pkg::bus_dev_e exp);
        if (got !== exp) begin
            $display("** Error %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_targ(input string name, input ctrl_pkg::targ_dev_e got,
                              input ctrl_pkg::targ_dev_e exp);
        if (got !== exp) begin
            $display("** Error %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_alu(input string name, input ctrl_pkg::alu_op_e got,
                             input ctrl_pkg::alu_op_e exp);
        if (got !== exp) begin
            $display("** Error %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input logic [ctrl_pkg::addr_width-1:0] got,
                              input logic [ctrl_pkg::addr_width-1:0] exp);
        if (got !== exp) begin
            $display("** Error %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_byte(input string name, input logic [ctrl_pkg::data_width-1:0] got,
                              input logic [ctrl_pkg::data_width-1:0] exp);
        if (got !== exp) begin
            $display("** Error %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    // wait for fetch, put the word on rom_data, keep it until fetch is over
    task automatic present_word(input logic [ctrl_pkg::rom_width-1:0] word);
        int n;
        n = 0;
        @(negedge clk);
        while (addrmode_pc_n && n < fetch_timeout) begin
            drive_garbage();  // outside fetch the rom bus is noise
            @(negedge clk);
            n++;
        end
        if (addrmode_pc_n) begin
            $display("timeout: no fetch phase within %0d cycles", fetch_timeout);
            timeouts++;
        end
        rom_data = word;
        n = 0;
        @(negedge clk);
        while (!addrmode_pc_n && n < hold_timeout) begin
            @(negedge clk);
            n++;
        end
        if (!addrmode_pc_n) begin
            $display("timeout: fetch phase did not end within %0d cycles", hold_timeout);
            timeouts++;
        end
        drive_garbage();  // ir must already hold the word by now
    endtask

    // execute shows up as a write target; a no-op line just runs out the loop
    task automatic wait_for_execute(input bit expect_write);
        int n;
        n = 0;
        @(negedge clk);
        while (targ_dev == ctrl_pkg::targ_none && n < exec_timeout) begin
            drive_garbage();
            @(negedge clk);
            n++;
        end
        if (expect_write && targ_dev == ctrl_pkg::targ_none) begin
            $display("timeout: no write target appeared during execute (pc %h)", pc);
            timeouts++;
        end
    endtask

    task automatic check_outputs(input logic [ctrl_pkg::rom_width-1:0] word,
                                 input ctrl_pkg::bus_dev_e rb, input ctrl_pkg::bus_dev_e lb,
                                 input ctrl_pkg::targ_dev_e tg, input ctrl_pkg::alu_op_e al,
                                 input logic mode, input logic [ctrl_pkg::addr_width-1:0] pcx);
        check_bus("rbus_dev", rbus_dev, rb);
        check_bus("lbus_dev", lbus_dev, lb);
        check_targ("targ_dev", targ_dev, tg);
        check_alu("aluop", aluop, al);
        check_bit("addrmode_pc_n", addrmode_pc_n, 1'b1);         // not fetching
        check_bit("addrmode_register_n", addrmode_register_n, mode);
        check_bit("addrmode_direct_n", addrmode_direct_n, ~mode);
        check_addr("direct_addr", direct_addr, word[15:0]);   // low half of the word
        check_byte("imm8", imm8, word[7:0]);
        check_addr("pc", pc, pcx);
    endtask

    // one golden line, checked early in execute and again near its end
    task automatic run_line(input logic [ctrl_pkg::rom_width-1:0] word,
                            input ctrl_pkg::bus_dev_e rb, input ctrl_pkg::bus_dev_e lb,
                            input ctrl_pkg::targ_dev_e tg, input ctrl_pkg::alu_op_e al,
                            input logic mode, input logic [ctrl_pkg::addr_width-1:0] pcx);
        present_word(word);
        wait_for_execute(tg != ctrl_pkg::targ_none);
        check_outputs(word, rb, lb, tg, al, mode, pcx);
        repeat (3) begin
            @(negedge clk);
            drive_garbage();  // rom_data keeps moving, selects must not
        end
        check_outputs(word, rb, lb, tg, al, mode, pcx);
    endtask

    initial begin
        int          fd;
        int          code;
        string       line;
        logic [31:0] f_rom, f_rb, f_lb, f_tg, f_al, f_md, f_pc;
        arst_n       = 1'b0;
        rom_data     = '0;
        lfsr         = 32'h196c7ca3;
        errors       = 0;
        timeouts     = 0;
        assert_fails = 0;
        lines_run    = 0;
        repeat (reset_cycles) @(negedge clk);
        // reset state, still inside reset
        check_bit("addrmode_pc_n", addrmode_pc_n, 1'b0);
        check_addr("pc", pc, '0);
        check_targ("targ_dev", targ_dev, ctrl_pkg::targ_none);
        check_bus("rbus_dev", rbus_dev, ctrl_pkg::bus_none);
        check_bus("lbus_dev", lbus_dev, ctrl_pkg::bus_none);
        arst_n = 1'b1;

        fd = $fopen("cpu_control_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open cpu_control_golden.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code != 0 && line.len() > 1 && line.getc(0) != 8'h23) begin  // skip # lines
                    code = $sscanf(line, "%h %h %h %h %h %h %h",
                                   f_rom, f_rb, f_lb, f_tg, f_al, f_md, f_pc);
                    if (code != 7) begin
                        $display("golden line could not be parsed: %s", line);
                        errors++;
                    end else begin
                        run_line(f_rom[ctrl_pkg::rom_width-1:0],
                                 ctrl_pkg::bus_dev_e'(f_rb[3:0]),
                                 ctrl_pkg::bus_dev_e'(f_lb[3:0]),
                                 ctrl_pkg::targ_dev_e'(f_tg[4:0]),
                                 ctrl_pkg::alu_op_e'(f_al[4:0]),
                                 f_md[0], f_pc[ctrl_pkg::addr_width-1:0]);
                        lines_run++;
                    end
                end
            end
            $fclose(fd);
            if (lines_run == 0) begin
                $display("golden file held no instructions");
                errors++;
            end
        end

        assert_fails = cpu_control_inst.cpu_control_assertions_inst.failures;
        $display("instructions %0d, errors %0d, timeouts %0d, assertion failures %0d",
                 lines_run, errors, timeouts, assert_fails);
        if (errors == 0 && timeouts == 0 && assert_fails == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== cpu_control_golden.txt ====
# rom_word rbus lbus targ aluop mode pc, all hex
# mode 0 expects register addressing in execute, 1 expects direct
020463 3 2 02 03 0 0000
06E8A7 5 4 06 07 0 0001
1A1395 c 9 1a 15 0 0002
2100A5 0 f 01 02 0 0003
237F3C 0 f 03 02 0 0004
401234 0 f 00 02 0 0005
82BEEF 0 f 02 02 1 0006
A40100 1 f 04 02 1 0007
C32040 f 3 08 01 1 0008
D5FFFF f 5 08 01 1 0009
654321 f f 1f 02 0 000a
FFFFFF f f 1f 02 1 000b
08003F 1 0 08 1f 0 000c
BE8000 1 f 1e 02 1 000d
800000 0 f 00 02 1 000e
2700FF 0 f 07 02 0 000f
600000 f f 1f 02 0 0010
050EC6 6 7 05 06 0 0011

// ==== vlog.f ====
ctrl_pkg.sv
phaser.sv
fetch_unit.sv
control_selector.sv
cpu_control.sv
cpu_control_assertions.sv
tb_cpu_control.sv

// ==== Makefile ====
# Verilator build and run of the cpu control testbench

SRCS := $(wildcard *.sv)
BIN  := obj_dir/tb_cpu_control

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) vlog.f
	verilator --binary -j 0 --assert -Wno-fatal --top-module tb_cpu_control \
		-f vlog.f -Mdir obj_dir -o tb_cpu_control

run: $(BIN)
	./$(BIN) > sim.log 2>&1 || echo "TEST RESULT: FAIL" >> sim.log
	cat sim.log
	! grep -q "TEST RESULT: FAIL" sim.log

clean:
	rm -rf obj_dir sim.log
